/* rtl/div_settings.svh */
// divide unit settings
// operand width and radix-2 iteration count
// width fixed by the rv32 m extension semantics
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and result width in bits
`define DIV_WIDTH 32

// restoring divider retires one quotient bit per step
`define DIV_STEPS `DIV_WIDTH

// most negative signed operand, used for overflow detection
`define DIV_MIN_INT {1'b1, {(`DIV_WIDTH-1){1'b0}}}

`endif

/* rtl/div_types_pkg.sv */
// divide unit data types
// operand word, operation code and the request/response payloads
`include "div_settings.svh"

package div_types_pkg;

    // one operand or result word
    typedef logic [`DIV_WIDTH-1:0] word_t;

    // bit 0 set for unsigned, bit 1 set for remainder
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_t;

    // held stable by the requester while req is high
    typedef struct packed {
        div_op_t op;
        word_t   dividend;
        word_t   divisor;
    } div_request_t;

    // quotient or remainder, whichever the op asked for
    typedef struct packed {
        word_t result;
    } div_response_t;

endpackage

/* rtl/div_ctrl_pkg.sv */
// divide unit control types
// sequencing states, iteration index and the flags kept for result fixup
`include "div_settings.svh"

package div_ctrl_pkg;

    // handshake and sequencing states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } div_state_t;

    // index of the current divider step, 0 to DIV_STEPS-1
    typedef logic [$clog2(`DIV_STEPS)-1:0] iter_count_t;

    // captured at load, consumed by the fixup logic
    typedef struct packed {
        // sign of the quotient differs from the magnitude result
        logic                  negate_q;
        // remainder follows the dividend sign
        logic                  negate_r;
        // risc-v special cases
        logic                  div_zero;
        logic                  overflow;
        // rem/remu rather than div/divu
        logic                  want_rem;
        // original dividend, returned by both special cases
        div_types_pkg::word_t  dividend;
    } div_fix_t;

endpackage

/* rtl/div_sign_prep.sv */
// divide sign preparation
// turns signed operands into magnitudes for the unsigned divider core and
// registers the sign and special-case flags needed to fix up the result
`include "div_settings.svh"

module div_sign_prep (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load,
    input  div_types_pkg::div_request_t  request,
    output div_types_pkg::word_t         dividend_mag,
    output div_types_pkg::word_t         divisor_mag,
    output div_ctrl_pkg::div_fix_t       fix
);

    logic                    signed_op;
    logic                    dividend_neg;
    logic                    divisor_neg;
    div_ctrl_pkg::div_fix_t  fix_d;

    // div and rem treat operands as two's complement
    assign signed_op = (request.op == div_types_pkg::OP_DIV) ||
                       (request.op == div_types_pkg::OP_REM);

    assign dividend_neg = signed_op && request.dividend[`DIV_WIDTH-1];
    assign divisor_neg  = signed_op && request.divisor[`DIV_WIDTH-1];

    // min int magnitude 2^(w-1) still fits unsigned
    assign dividend_mag = dividend_neg ? -request.dividend : request.dividend;
    assign divisor_mag  = divisor_neg  ? -request.divisor  : request.divisor;

    always_comb begin
        fix_d.negate_q = dividend_neg ^ divisor_neg;
        fix_d.negate_r = dividend_neg;
        fix_d.div_zero = (request.divisor == '0);
        // min int / -1 only matters for signed ops
        fix_d.overflow = signed_op && (request.dividend == `DIV_MIN_INT) &&
                         (request.divisor == '1);
        fix_d.want_rem = (request.op == div_types_pkg::OP_REM) ||
                         (request.op == div_types_pkg::OP_REMU);
        fix_d.dividend = request.dividend;
    end

    // flags captured on load
    always_ff @(posedge clk) begin
        if (rst) begin
            fix.negate_q <= 1'b0;
            fix.negate_r <= 1'b0;
            fix.div_zero <= 1'b0;
            fix.overflow <= 1'b0;
            fix.want_rem <= 1'b0;
        end else if (load) begin
            fix <= fix_d;
        end
    end

    // overflow means both operands negative as signed values, never for unsigned ops
    a_no_unsigned_overflow: assert property (@(posedge clk) disable iff (rst)
        fix.overflow |-> fix.negate_r && !fix.negate_q);

endmodule

/* rtl/div_cycle_counter.sv */
// divide iteration counter
// counts restoring steps and flags the final one
`include "div_settings.svh"

module div_cycle_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic last
);

    div_ctrl_pkg::iter_count_t index;

    // load restarts at step 0, each step advances by one
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (load) begin
            index <= '0;
        end else if (step) begin
            // wraps to 0 after the final step, harmless since the fsm stops
            index <= index + 1'b1;
        end
    end

    // final divider step in progress
    assign last = (index == div_ctrl_pkg::iter_count_t'(`DIV_STEPS - 1));

    // once the final step is taken nothing steps again until the next load
    a_no_step_past_last: assert property (@(posedge clk) disable iff (rst)
        step && last |=> !step);

endmodule

/* rtl/div_core_fsm.sv */
// divide sequencing fsm
// four-phase req/ack handshake around a fixed-latency divider run
// one load, DIV_STEPS steps, then ack held until req drops

module div_core_fsm (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic last,
    output logic load,
    output logic step,
    output logic ack
);

    div_ctrl_pkg::div_state_t state;
    div_ctrl_pkg::div_state_t state_next;
    logic                     ack_next;

    // capture operands on the first edge idle sees req
    assign load = (state == div_ctrl_pkg::ST_IDLE) && req;

    // every run cycle is a divider step
    assign step = (state == div_ctrl_pkg::ST_RUN);

    always_comb begin
        state_next = state;
        ack_next   = ack;
        case (state)
            div_ctrl_pkg::ST_IDLE: begin
                if (req) begin
                    state_next = div_ctrl_pkg::ST_RUN;
                end
            end
            div_ctrl_pkg::ST_RUN: begin
                // result valid right after the final step
                if (step && last) begin
                    state_next = div_ctrl_pkg::ST_DONE;
                    ack_next   = 1'b1;
                end
            end
            div_ctrl_pkg::ST_DONE: begin
                // hold ack and result while requester keeps req high
                if (!req) begin
                    state_next = div_ctrl_pkg::ST_IDLE;
                    ack_next   = 1'b0;
                end
            end
            default: begin
                state_next = div_ctrl_pkg::ST_IDLE;
                ack_next   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_ctrl_pkg::ST_IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= ack_next;
        end
    end

    // ack only comes out of the final run step
    a_ack_after_last: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past((state == div_ctrl_pkg::ST_RUN) && last));

    // a new request is taken only when idle with the previous ack gone
    a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
        load |-> (state == div_ctrl_pkg::ST_IDLE) && !ack);

endmodule

/* rtl/div_iter_datapath.sv */
// radix-2 restoring divider datapath
// unsigned magnitudes in, one quotient bit per step, quotient and
// remainder held once the run completes
`include "div_settings.svh"

module div_iter_datapath (
    input  logic                  clk,
    input  logic                  load,
    input  logic                  step,
    input  div_types_pkg::word_t  dividend_mag,
    input  div_types_pkg::word_t  divisor_mag,
    output div_types_pkg::word_t  quotient,
    output div_types_pkg::word_t  remainder
);

    // partial remainder, one extra bit since it can reach 2*divisor-1
    logic [`DIV_WIDTH:0]   pr;
    logic [`DIV_WIDTH:0]   new_pr;
    logic                  sub_neg;
    // dividend bits not yet shifted into pr
    div_types_pkg::word_t  ar;
    div_types_pkg::word_t  divisor_r;
    div_types_pkg::word_t  q_r;

    // trial subtraction
    assign new_pr  = pr - {1'b0, divisor_r};
    // borrow means pr < divisor, keep pr
    assign sub_neg = new_pr[`DIV_WIDTH];

    always_ff @(posedge clk) begin
        if (load) begin
            // first dividend bit already brought into pr
            pr        <= {{`DIV_WIDTH{1'b0}}, dividend_mag[`DIV_WIDTH-1]};
            ar        <= {dividend_mag[`DIV_WIDTH-2:0], 1'b0};
            divisor_r <= divisor_mag;
            q_r       <= '0;
        end else if (step) begin
            // restore or take the difference, then bring in the next bit
            if (sub_neg) begin
                pr <= {pr[`DIV_WIDTH-1:0], ar[`DIV_WIDTH-1]};
            end else begin
                pr <= {new_pr[`DIV_WIDTH-1:0], ar[`DIV_WIDTH-1]};
            end
            ar  <= {ar[`DIV_WIDTH-2:0], 1'b0};
            // quotient bit is 1 when the subtraction succeeded
            q_r <= {q_r[`DIV_WIDTH-2:0], !sub_neg};
        end
    end

    assign quotient = q_r;

    // final step shifted a zero into pr[0], the remainder sits above it
    assign remainder = pr[`DIV_WIDTH:1];

    // restoring invariant, true after every step and so after the last one
    a_rem_below_divisor: assert property (@(posedge clk)
        step && (divisor_r != '0) |=> remainder < divisor_r);

endmodule

/* rtl/div_result_fixup.sv */
// divide result fixup
// applies operand signs to the magnitude results, substitutes the
// risc-v divide-by-zero and overflow results, picks quotient or remainder

module div_result_fixup (
    input  div_types_pkg::word_t           quotient,
    input  div_types_pkg::word_t           remainder,
    input  div_ctrl_pkg::div_fix_t         fix,
    output div_types_pkg::div_response_t   response
);

    div_types_pkg::word_t q_signed;
    div_types_pkg::word_t r_signed;
    div_types_pkg::word_t q_final;
    div_types_pkg::word_t r_final;

    // sign correction, unsigned ops never set the negate flags
    assign q_signed = fix.negate_q ? -quotient  : quotient;
    assign r_signed = fix.negate_r ? -remainder : remainder;

    always_comb begin
        if (fix.div_zero) begin
            // x / 0: all ones, remainder is the dividend
            q_final = '1;
            r_final = fix.dividend;
        end else if (fix.overflow) begin
            // min / -1: quotient wraps back to the dividend
            q_final = fix.dividend;
            r_final = '0;
        end else begin
            q_final = q_signed;
            r_final = r_signed;
        end
    end

    // rem and remu return the remainder
    assign response.result = fix.want_rem ? r_final : q_final;

endmodule

/* rtl/div_unit.sv */
// integer divide unit
// div, divu, rem and remu over a four-phase req/ack handshake
// fixed latency radix-2 restoring divider, one request in flight

module div_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  div_types_pkg::div_request_t    request,
    output logic                           ack,
    output div_types_pkg::div_response_t   response
);

    logic                    load;
    logic                    step;
    logic                    last;
    div_types_pkg::word_t    dividend_mag;
    div_types_pkg::word_t    divisor_mag;
    div_types_pkg::word_t    quotient;
    div_types_pkg::word_t    remainder;
    div_ctrl_pkg::div_fix_t  fix;

    // handshake and sequencing
    div_core_fsm u_fsm (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .last (last),
        .load (load),
        .step (step),
        .ack  (ack)
    );

    div_cycle_counter u_counter (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .step (step),
        .last (last)
    );

    // magnitudes now, sign flags for later
    div_sign_prep u_sign_prep (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .request      (request),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .fix          (fix)
    );

    div_iter_datapath u_datapath (
        .clk          (clk),
        .load         (load),
        .step         (step),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    // combinational, response follows the held datapath registers
    div_result_fixup u_fixup (
        .quotient  (quotient),
        .remainder (remainder),
        .fix       (fix),
        .response  (response)
    );

endmodule

/* bench/div_unit_tb.sv */
// testbench for the integer divide unit
// runs four-phase req/ack transactions and checks each result
// against a model of the risc-v division rules
`include "div_settings.svh"

module div_unit_tb;

    localparam int ACK_TIMEOUT = 200;
    // load edge plus one edge per divider step
    localparam int ACK_LATENCY = `DIV_STEPS + 1;

    logic                          clk;
    logic                          rst;
    logic                          req;
    div_types_pkg::div_request_t   request;
    logic                          ack;
    div_types_pkg::div_response_t  response;

    // requests issued but not yet acked
    div_types_pkg::div_request_t   pending[$];
    div_types_pkg::div_request_t   cur_req;
    div_types_pkg::word_t          held_result;
    logic                          ack_prev;
    int                            sent;
    int                            checked;

    div_unit u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rv32m rules for div by zero, signed overflow and truncating division
    function automatic div_types_pkg::word_t ref_result(
        input div_types_pkg::div_request_t r
    );
        logic signed [`DIV_WIDTH-1:0] a;
        logic signed [`DIV_WIDTH-1:0] b;
        logic                         zero;
        logic                         ovf;
        div_types_pkg::word_t         res;
        a    = r.dividend;
        b    = r.divisor;
        zero = (r.divisor == '0);
        ovf  = (r.dividend == `DIV_MIN_INT) && (r.divisor == '1);
        case (r.op)
            div_types_pkg::OP_DIV: begin
                if (zero || ovf) begin
                    res = zero ? '1 : r.dividend;
                end else begin
                    // both operands signed, so truncating signed division
                    res = a / b;
                end
            end
            div_types_pkg::OP_REM: begin
                if (zero || ovf) begin
                    res = zero ? r.dividend : '0;
                end else begin
                    // sign follows the dividend
                    res = a % b;
                end
            end
            div_types_pkg::OP_DIVU: res = zero ? '1 : r.dividend / r.divisor;
            default:                res = zero ? r.dividend : r.dividend % r.divisor;
        endcase
        return res;
    endfunction

    function automatic string describe(input div_types_pkg::div_request_t r);
        return $sformatf("%s %h / %h", r.op.name(), r.dividend, r.divisor);
    endfunction

    task automatic compare_word(input string what, input div_types_pkg::word_t expected,
                                input div_types_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: expected %h, got %h", $time, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopped on error");
    endtask

    // result checked on each rise of ack and held while ack stays high
    always @(negedge clk) begin
        if (rst) begin
            ack_prev = 1'b0;
        end else begin
            if (ack && !ack_prev) begin
                if (pending.size() == 0) begin
                    stop_run("ack rose with no request outstanding");
                end
                cur_req     = pending.pop_front();
                held_result = response.result;
                compare_word(describe(cur_req), ref_result(cur_req), response.result);
                checked++;
            end else if (ack) begin
                compare_word({describe(cur_req), " held"}, held_result, response.result);
            end
            ack_prev = ack;
        end
    end

    // one full handshake with req kept high for hold cycles after ack
    task automatic run_request(input div_types_pkg::div_op_t op,
                               input div_types_pkg::word_t dividend,
                               input div_types_pkg::word_t divisor, input int hold);
        int edges;
        edges = 0;
        while (ack) begin
            @(negedge clk);
            edges++;
            if (edges > ACK_TIMEOUT) begin
                stop_run("timeout waiting for ack low before raising req");
            end
        end
        request = '{op: op, dividend: dividend, divisor: divisor};
        req     = 1'b1;
        pending.push_back(request);
        sent++;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
            if (edges > ACK_TIMEOUT) begin
                stop_run("timeout waiting for ack to rise after req");
            end
        end while (!ack);
        compare_word({describe(request), " ack latency"}, ACK_LATENCY, edges);
        repeat (hold) begin
            @(negedge clk);
            compare_word("ack held while req high", 1, ack);
        end
        req = 1'b0;
        // payload is free once req is low
        request.dividend = $urandom;
        request.divisor  = $urandom;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
            if (edges > ACK_TIMEOUT) begin
                stop_run("timeout waiting for ack to fall after req dropped");
            end
        end while (ack);
        compare_word("ack fall delay after req low", 1, edges);
    endtask

    initial begin
        div_types_pkg::word_t    a;
        div_types_pkg::word_t    b;
        div_types_pkg::div_op_t  op;
        void'($urandom(32'hc1f3_84f4));
        rst     = 1'b1;
        req     = 1'b0;
        request = '0;
        sent    = 0;
        checked = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (10) begin
            @(negedge clk);
            compare_word("ack idle after reset", 0, ack);
        end

        // unsigned ops with divisors of many sizes
        for (int i = 0; i < 40; i++) begin
            op = ($urandom % 2) ? div_types_pkg::OP_REMU : div_types_pkg::OP_DIVU;
            run_request(op, $urandom, ($urandom >> ($urandom % 32)) | 1, 0);
        end

        // signed ops over all four sign combinations
        for (int i = 0; i < 48; i++) begin
            a  = $urandom >> 1;
            b  = ($urandom >> (1 + $urandom % 31)) + 1;
            a  = (i % 2) ? -a : a;
            b  = ((i / 2) % 2) ? -b : b;
            op = ((i / 4) % 2) ? div_types_pkg::OP_REM : div_types_pkg::OP_DIV;
            run_request(op, a, b, 0);
        end
        run_request(div_types_pkg::OP_REM, -7, 2, 0);
        run_request(div_types_pkg::OP_REM, 7, -2, 0);
        run_request(div_types_pkg::OP_DIV, -7, 2, 0);

        // divide by zero and min / -1
        for (int k = 0; k < 4; k++) begin
            op = div_types_pkg::div_op_t'(k);
            run_request(op, $urandom, '0, 0);
            run_request(op, '0, '0, 0);
            run_request(op, `DIV_MIN_INT, '1, 0);
        end

        // requester holds req after ack and then goes back to back
        for (int i = 0; i < 12; i++) begin
            op = div_types_pkg::div_op_t'($urandom % 4);
            run_request(op, $urandom, $urandom >> ($urandom % 32), 1 + $urandom % 8);
        end
        for (int i = 0; i < 6; i++) begin
            op = div_types_pkg::div_op_t'($urandom % 4);
            run_request(op, $urandom, $urandom >> ($urandom % 32), 0);
        end

        repeat (4) @(negedge clk);
        if (pending.size() == 0 && checked == sent) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_run("some requests were never acked and checked");
        end
    end

endmodule

/* div_unit.f */
+incdir+rtl
rtl/div_types_pkg.sv
rtl/div_ctrl_pkg.sv
rtl/div_sign_prep.sv
rtl/div_cycle_counter.sv
rtl/div_core_fsm.sv
rtl/div_iter_datapath.sv
rtl/div_result_fixup.sv
rtl/div_unit.sv
bench/div_unit_tb.sv

/* Bender.yml */
package:
  name: div_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/div_types_pkg.sv
      - rtl/div_ctrl_pkg.sv
      - rtl/div_sign_prep.sv
      - rtl/div_cycle_counter.sv
      - rtl/div_core_fsm.sv
      - rtl/div_iter_datapath.sv
      - rtl/div_result_fixup.sv
      - rtl/div_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/div_unit_tb.sv
